// ==== Makefile ====
TOP = tb_rx_scheduler

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f files.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f files.f \
		-Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q '\*\* FAIL \*\*' sim.log; then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q '\*\* PASS \*\*' sim.log; then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== files.f ====
hw/sched_pkg.sv
hw/desc_grant_if.sv
hw/slot_keeper.sv
hw/desc_dispatcher.sv
hw/rx_port_ctrl.sv
hw/host_cmd_regs.sv
hw/rx_scheduler.sv
tb/tb_rx_scheduler.sv

// ==== hw/desc_dispatcher.sv ====
`default_nettype none

module desc_dispatcher import sched_pkg::*; (
  input  logic                                  clk,
  input  logic                                  rst_r,
  desc_grant_if.dispatcher                      grant_bus,
  input  logic [CORE_COUNT-1:0]                 income_cores,
  input  logic [CORE_COUNT-1:0]                 slot_valid,
  input  logic [CORE_COUNT-1:0][SLOT_WIDTH-1:0] counts,
  input  logic [CORE_COUNT-1:0][SLOT_WIDTH-1:0] slot_out,
  output logic [CORE_COUNT-1:0]                 core_pop
);

  logic [IF_COUNT-1:0]      grant_r;
  logic [IF_COUNT-1:0]      next_grant;
  logic [IF_ID_WIDTH-1:0]   last_port;
  logic [IF_ID_WIDTH-1:0]   next_port;
  logic [CORE_COUNT-1:0]    core_ok;
  logic                     best_valid;
  logic [CORE_ID_WIDTH-1:0] best_core;
  logic [SLOT_WIDTH-1:0]    best_count;
  logic                     pop;

  // Round robin search starting after the last served port
  always_comb begin
    int idx;
    next_grant = '0;
    next_port  = last_port;
    for (int off = 1; off <= IF_COUNT; off++) begin
      idx = (int'(last_port) + off) % IF_COUNT;
      if (grant_bus.req[idx] && next_grant == '0) begin
        next_grant[idx] = 1'b1;
        next_port       = IF_ID_WIDTH'(idx);
      end
    end
  end

  // Grant is held until a core has a slot for it
  always_ff @(posedge clk) begin
    if (rst_r) begin
      grant_r   <= '0;
      last_port <= IF_ID_WIDTH'(IF_COUNT - 1);
    end else if (pop) begin
      grant_r <= '0;
    end else if (grant_r == '0 && next_grant != '0) begin
      grant_r   <= next_grant;
      last_port <= next_port;
    end
  end

  // Strict compare keeps the lowest index on ties among the open cores
  assign core_ok = income_cores & slot_valid;

  always_comb begin
    best_valid = 1'b0;
    best_core  = '0;
    best_count = '0;
    for (int i = 0; i < CORE_COUNT; i++) begin
      if (core_ok[i] && (!best_valid || counts[i] > best_count)) begin
        best_valid = 1'b1;
        best_core  = CORE_ID_WIDTH'(i);
        best_count = counts[i];
      end
    end
  end

  assign pop = (grant_r != '0) && best_valid;

  always_comb begin
    for (int i = 0; i < CORE_COUNT; i++) begin
      core_pop[i] = pop && (best_core == CORE_ID_WIDTH'(i));
    end
  end

  assign grant_bus.grant = grant_r;
  assign grant_bus.pop   = pop;
  assign grant_bus.desc  = {best_core, slot_out[best_core]};

  // Only slot numbers 1 to SLOT_COUNT may leave in a descriptor
  a_desc_slot_range: assert property (
    @(posedge clk) disable iff (rst_r)
    pop |-> grant_bus.desc[SLOT_WIDTH-1:0] != '0 &&
            grant_bus.desc[SLOT_WIDTH-1:0] <= SLOT_WIDTH'(SLOT_COUNT)
  );

endmodule

`default_nettype wire

// ==== hw/desc_grant_if.sv ====
`default_nettype none

interface desc_grant_if import sched_pkg::*;
();

  logic [IF_COUNT-1:0]     req;
  logic [IF_COUNT-1:0]     grant;
  logic                    pop;
  // Core number above slot number
  logic [ID_TAG_WIDTH-1:0] desc;

  modport dispatcher (
    input  req,
    output grant,
    output pop,
    output desc
  );

  modport port (
    output req,
    input  grant,
    input  pop,
    input  desc
  );

endinterface

`default_nettype wire

// ==== hw/host_cmd_regs.sv ====
`default_nettype none

module host_cmd_regs import sched_pkg::*; (
  input  logic                                  clk,
  input  logic                                  rst_r,
  input  logic [31:0]                           host_cmd,
  input  logic [31:0]                           host_cmd_wr_data,
  input  logic                                  host_cmd_valid,
  output logic [31:0]                           host_cmd_rd_data,
  output logic [CORE_COUNT-1:0]                 income_cores,
  output logic [CORE_COUNT-1:0]                 slot_flush,
  input  logic [CORE_COUNT-1:0][SLOT_WIDTH-1:0] counts,
  input  port_state_e                           port_states [IF_COUNT],
  input  logic [ID_TAG_WIDTH-1:0]               port_tags [IF_COUNT]
);

  logic                     wr_r;
  host_reg_e                reg_r;
  logic [CORE_ID_WIDTH-1:0] index_r;
  logic [31:0]              wr_data_r;
  logic [CORE_COUNT-1:0]    enabled_cores;
  logic [CORE_COUNT-1:0]    wr_mask;
  logic [IF_ID_WIDTH-1:0]   port_sel;
  logic [ID_TAG_WIDTH-1:0]  port_tag;

  assign wr_mask  = wr_data_r[CORE_COUNT-1:0];
  assign port_sel = index_r[IF_ID_WIDTH-1:0];
  assign port_tag = port_tags[port_sel];

  always_ff @(posedge clk) begin
    reg_r     <= host_reg_e'({host_cmd[HOST_GROUP_BIT], host_cmd[3:0]});
    index_r   <= host_cmd[HOST_INDEX_LSB +: CORE_ID_WIDTH];
    wr_data_r <= host_cmd_wr_data;
    if (rst_r) begin
      wr_r <= 1'b0;
    end else begin
      wr_r <= host_cmd_valid && host_cmd[HOST_WR_BIT] && host_cmd[HOST_SCHED_BIT];
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      enabled_cores <= '0;
      income_cores  <= '0;
      slot_flush    <= '0;
    end else begin
      slot_flush <= '0;
      if (wr_r) begin
        case (reg_r)
          REG_CORE_ENABLE: begin
            // A core being disabled stops taking traffic too
            enabled_cores <= wr_mask;
            income_cores  <= income_cores & wr_mask;
          end
          REG_CORE_INCOME: income_cores <= wr_mask & enabled_cores;
          REG_SLOT_FLUSH:  slot_flush   <= wr_mask;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      host_cmd_rd_data <= '0;
    end else begin
      case (reg_r)
        REG_CORE_ENABLE: host_cmd_rd_data <= 32'(enabled_cores);
        REG_CORE_INCOME: host_cmd_rd_data <= 32'(income_cores);
        REG_SLOT_COUNT:  host_cmd_rd_data <= 32'(counts[index_r]);
        REG_PORT_STATUS: begin
          if (index_r < IF_COUNT) begin
            host_cmd_rd_data <= {14'd0, port_states[port_sel], 5'd0,
                                 port_tag[ID_TAG_WIDTH-1 -: CORE_ID_WIDTH], 3'd0,
                                 port_tag[SLOT_WIDTH-1:0]};
          end else begin
            host_cmd_rd_data <= HOST_RD_DEFAULT;
          end
        end
        default: host_cmd_rd_data <= HOST_RD_DEFAULT;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/rx_port_ctrl.sv ====
`default_nettype none

module rx_port_ctrl import sched_pkg::*; #(
  parameter int PORT_ID = 0
) (
  input  logic                    clk,
  input  logic                    rst_r,
  desc_grant_if.port              grant_bus,

  input  logic [DATA_WIDTH-1:0]   rx_tdata,
  input  logic [KEEP_WIDTH-1:0]   rx_tkeep,
  input  logic                    rx_tvalid,
  output logic                    rx_tready,
  input  logic                    rx_tlast,

  output logic [DATA_WIDTH-1:0]   data_tdata,
  output logic [KEEP_WIDTH-1:0]   data_tkeep,
  output logic [ID_TAG_WIDTH-1:0] data_tdest,
  output logic                    data_tvalid,
  input  logic                    data_tready,
  output logic                    data_tlast,

  output port_state_e             state,
  output logic [ID_TAG_WIDTH-1:0] pending_tag
);

  logic                    got_desc;
  logic                    open;
  logic                    accept;
  logic                    last_word;
  logic [ID_TAG_WIDTH-1:0] packet_tag;

  assign got_desc  = grant_bus.pop && grant_bus.grant[PORT_ID];
  assign open      = (state != STALL);
  assign accept    = rx_tvalid && rx_tready;
  assign last_word = accept && rx_tlast;

  // Pass-through path, closed while the port has no descriptor
  assign rx_tready   = open && data_tready;
  assign data_tvalid = open && rx_tvalid;
  assign data_tdata  = rx_tdata;
  assign data_tkeep  = rx_tkeep;
  assign data_tlast  = rx_tlast;
  assign data_tdest  = (state == FIRST) ? pending_tag : packet_tag;

  // Prefetch the next descriptor as soon as the current one is in use
  assign grant_bus.req[PORT_ID] = !grant_bus.grant[PORT_ID] &&
                                  (state == STALL || state == WAIT ||
                                   (state == FIRST && accept));

  always_ff @(posedge clk) begin
    if (rst_r) begin
      state <= STALL;
    end else begin
      case (state)
        STALL: if (got_desc) state <= FIRST;
        FIRST: begin
          if (last_word) begin
            state <= STALL;
          end else if (accept) begin
            state <= WAIT;
          end
        end
        WAIT: begin
          if (got_desc && last_word) begin
            state <= FIRST;
          end else if (got_desc) begin
            state <= MID;
          end else if (last_word) begin
            state <= STALL;
          end
        end
        MID: if (last_word) state <= FIRST;
        default: state <= STALL;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      pending_tag <= '0;
    end else if (got_desc) begin
      pending_tag <= grant_bus.desc;
    end
  end

  // Tag is frozen for the rest of the packet at its first word
  always_ff @(posedge clk) begin
    if (state == FIRST && accept) begin
      packet_tag <= pending_tag;
    end
  end

  // Dispatcher only serves a port that has no spare descriptor
  a_desc_when_needed: assert property (
    @(posedge clk) disable iff (rst_r)
    got_desc |-> (state == STALL || state == WAIT)
  );

endmodule

`default_nettype wire

// ==== hw/rx_scheduler.sv ====
`default_nettype none

module rx_scheduler import sched_pkg::*; (
  input  logic                             clk,
  input  logic                             rst_r,

  input  logic [IF_COUNT*DATA_WIDTH-1:0]   rx_tdata,
  input  logic [IF_COUNT*KEEP_WIDTH-1:0]   rx_tkeep,
  input  logic [IF_COUNT-1:0]              rx_tvalid,
  output logic [IF_COUNT-1:0]              rx_tready,
  input  logic [IF_COUNT-1:0]              rx_tlast,

  output logic [IF_COUNT*DATA_WIDTH-1:0]   data_tdata,
  output logic [IF_COUNT*KEEP_WIDTH-1:0]   data_tkeep,
  output logic [IF_COUNT*ID_TAG_WIDTH-1:0] data_tdest,
  output logic [IF_COUNT-1:0]              data_tvalid,
  input  logic [IF_COUNT-1:0]              data_tready,
  output logic [IF_COUNT-1:0]              data_tlast,

  input  logic [CTRL_WIDTH-1:0]            ctrl_tdata,
  input  logic                             ctrl_tvalid,
  input  logic [CORE_ID_WIDTH-1:0]         ctrl_tuser,

  input  logic [31:0]                      host_cmd,
  input  logic [31:0]                      host_cmd_wr_data,
  input  logic                             host_cmd_valid,
  output logic [31:0]                      host_cmd_rd_data
);

  desc_grant_if grant_bus ();

  logic                                  ctrl_valid_r;
  msg_type_e                             ctrl_type_r;
  logic [CORE_ID_WIDTH-1:0]              ctrl_core_r;
  logic [SLOT_WIDTH-1:0]                 ctrl_slot_r;
  logic [CORE_COUNT-1:0]                 init_strobe;
  logic [CORE_COUNT-1:0]                 free_strobe;
  logic [CORE_COUNT-1:0]                 slot_flush;
  logic [CORE_COUNT-1:0]                 income_cores;
  logic [CORE_COUNT-1:0]                 slot_valid;
  logic [CORE_COUNT-1:0]                 core_pop;
  logic [CORE_COUNT-1:0][SLOT_WIDTH-1:0] counts;
  logic [CORE_COUNT-1:0][SLOT_WIDTH-1:0] slot_out;
  port_state_e                           port_states [IF_COUNT];
  logic [ID_TAG_WIDTH-1:0]               port_tags [IF_COUNT];

  // Control input is always accepted, one register stage before decode
  always_ff @(posedge clk) begin
    ctrl_type_r <= msg_type_e'(ctrl_tdata[CTRL_WIDTH-1 -: MSG_TYPE_WIDTH]);
    ctrl_core_r <= ctrl_tuser;
    ctrl_slot_r <= ctrl_tdata[CTRL_SLOT_LSB +: SLOT_WIDTH];
    if (rst_r) begin
      ctrl_valid_r <= 1'b0;
    end else begin
      ctrl_valid_r <= ctrl_tvalid;
    end
  end

  host_cmd_regs u_host_regs (
    .clk              (clk),
    .rst_r            (rst_r),
    .host_cmd         (host_cmd),
    .host_cmd_wr_data (host_cmd_wr_data),
    .host_cmd_valid   (host_cmd_valid),
    .host_cmd_rd_data (host_cmd_rd_data),
    .income_cores     (income_cores),
    .slot_flush       (slot_flush),
    .counts           (counts),
    .port_states      (port_states),
    .port_tags        (port_tags)
  );

  desc_dispatcher u_dispatcher (
    .clk          (clk),
    .rst_r        (rst_r),
    .grant_bus    (grant_bus.dispatcher),
    .income_cores (income_cores),
    .slot_valid   (slot_valid),
    .counts       (counts),
    .slot_out     (slot_out),
    .core_pop     (core_pop)
  );

  for (genvar c = 0; c < CORE_COUNT; c++) begin : g_core
    assign init_strobe[c] = ctrl_valid_r && (ctrl_type_r == SLOT_INIT) &&
                            (ctrl_core_r == CORE_ID_WIDTH'(c));
    assign free_strobe[c] = ctrl_valid_r && (ctrl_type_r == SLOT_FREE) &&
                            (ctrl_core_r == CORE_ID_WIDTH'(c));

    slot_keeper u_keeper (
      .clk        (clk),
      .rst_r      (rst_r),
      .flush      (slot_flush[c]),
      .init_valid (init_strobe[c]),
      .free_valid (free_strobe[c]),
      .slot_in    (ctrl_slot_r),
      .pop        (core_pop[c]),
      .slot_out   (slot_out[c]),
      .slot_valid (slot_valid[c]),
      .count      (counts[c])
    );
  end

  for (genvar p = 0; p < IF_COUNT; p++) begin : g_port
    rx_port_ctrl #(
      .PORT_ID (p)
    ) u_port (
      .clk         (clk),
      .rst_r       (rst_r),
      .grant_bus   (grant_bus.port),
      .rx_tdata    (rx_tdata[p*DATA_WIDTH +: DATA_WIDTH]),
      .rx_tkeep    (rx_tkeep[p*KEEP_WIDTH +: KEEP_WIDTH]),
      .rx_tvalid   (rx_tvalid[p]),
      .rx_tready   (rx_tready[p]),
      .rx_tlast    (rx_tlast[p]),
      .data_tdata  (data_tdata[p*DATA_WIDTH +: DATA_WIDTH]),
      .data_tkeep  (data_tkeep[p*KEEP_WIDTH +: KEEP_WIDTH]),
      .data_tdest  (data_tdest[p*ID_TAG_WIDTH +: ID_TAG_WIDTH]),
      .data_tvalid (data_tvalid[p]),
      .data_tready (data_tready[p]),
      .data_tlast  (data_tlast[p]),
      .state       (port_states[p]),
      .pending_tag (port_tags[p])
    );
  end

endmodule

`default_nettype wire

// ==== hw/sched_pkg.sv ====
`default_nettype none

package sched_pkg;

  localparam int IF_COUNT       = 3;
  localparam int IF_ID_WIDTH    = 2;
  localparam int CORE_COUNT     = 8;
  localparam int SLOT_COUNT     = 16;
  // Slots are numbered from 1, so a full count of 16 still fits
  localparam int SLOT_WIDTH     = 5;
  localparam int SLOT_PTR_WIDTH = 4;
  localparam int CORE_ID_WIDTH  = 3;
  localparam int ID_TAG_WIDTH   = 8;
  localparam int DATA_WIDTH     = 64;
  localparam int KEEP_WIDTH     = 8;

  localparam int CTRL_WIDTH     = 36;
  localparam int MSG_TYPE_WIDTH = 4;
  localparam int CTRL_SLOT_LSB  = 16;

  // Host command word fields
  localparam int HOST_WR_BIT     = 31;
  localparam int HOST_GROUP_BIT  = 30;
  localparam int HOST_SCHED_BIT  = 29;
  localparam int HOST_INDEX_LSB  = 4;
  localparam logic [31:0] HOST_RD_DEFAULT = 32'hfefe_fefe;

  typedef enum logic [MSG_TYPE_WIDTH-1:0] {
    SLOT_FREE = 4'd0,
    SLOT_INIT = 4'd3
  } msg_type_e;

  typedef enum logic [1:0] {
    STALL = 2'd0,
    FIRST = 2'd1,
    WAIT  = 2'd2,
    MID   = 2'd3
  } port_state_e;

  // Top bit picks the core group or the interface group
  typedef enum logic [4:0] {
    REG_CORE_ENABLE = 5'h00,
    REG_CORE_INCOME = 5'h01,
    REG_SLOT_FLUSH  = 5'h02,
    REG_SLOT_COUNT  = 5'h03,
    REG_PORT_STATUS = 5'h10
  } host_reg_e;

endpackage

`default_nettype wire

// ==== hw/slot_keeper.sv ====
`default_nettype none

module slot_keeper import sched_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_r,
  input  logic                  flush,
  input  logic                  init_valid,
  input  logic                  free_valid,
  input  logic [SLOT_WIDTH-1:0] slot_in,
  input  logic                  pop,
  output logic [SLOT_WIDTH-1:0] slot_out,
  output logic                  slot_valid,
  output logic [SLOT_WIDTH-1:0] count
);

  logic [SLOT_WIDTH-1:0]     slots [SLOT_COUNT];
  logic [SLOT_PTR_WIDTH-1:0] rd_ptr;
  logic [SLOT_PTR_WIDTH-1:0] wr_ptr;
  logic                      do_pop;

  assign slot_valid = (count != '0);
  assign do_pop     = pop && slot_valid;
  assign slot_out   = slots[rd_ptr];

  // Init rewrites the whole ring with 1..SLOT_COUNT, count decides how many are live
  always_ff @(posedge clk) begin
    if (init_valid) begin
      for (int i = 0; i < SLOT_COUNT; i++) begin
        slots[i] <= SLOT_WIDTH'(i + 1);
      end
    end else if (free_valid) begin
      slots[wr_ptr] <= slot_in;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r || flush) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else if (init_valid) begin
      rd_ptr <= '0;
      wr_ptr <= slot_in[SLOT_PTR_WIDTH-1:0];
      count  <= slot_in;
    end else begin
      if (free_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + SLOT_WIDTH'(free_valid) - SLOT_WIDTH'(do_pop);
    end
  end

  // A core must never return more slots than the queue can hold
  a_no_overflow: assert property (
    @(posedge clk) disable iff (rst_r)
    free_valid && !flush && !init_valid && !do_pop |-> count < SLOT_WIDTH'(SLOT_COUNT)
  );

endmodule

`default_nettype wire

// ==== tb/tb_rx_scheduler.sv ====
`default_nettype none

module tb_rx_scheduler import sched_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int PKTS_PER_PORT = 24;
  localparam int MAX_PKT_WORDS = 6;
  localparam int WORD_BITS     = DATA_WIDTH + KEEP_WIDTH + 1;

  logic                             clk;
  logic                             rst_r;
  logic [IF_COUNT*DATA_WIDTH-1:0]   rx_tdata;
  logic [IF_COUNT*KEEP_WIDTH-1:0]   rx_tkeep;
  logic [IF_COUNT-1:0]              rx_tvalid;
  logic [IF_COUNT-1:0]              rx_tready;
  logic [IF_COUNT-1:0]              rx_tlast;
  logic [IF_COUNT*DATA_WIDTH-1:0]   data_tdata;
  logic [IF_COUNT*KEEP_WIDTH-1:0]   data_tkeep;
  logic [IF_COUNT*ID_TAG_WIDTH-1:0] data_tdest;
  logic [IF_COUNT-1:0]              data_tvalid;
  logic [IF_COUNT-1:0]              data_tready;
  logic [IF_COUNT-1:0]              data_tlast;
  logic [CTRL_WIDTH-1:0]            ctrl_tdata;
  logic                             ctrl_tvalid;
  logic [CORE_ID_WIDTH-1:0]         ctrl_tuser;
  logic [31:0]                      host_cmd;
  logic [31:0]                      host_cmd_wr_data;
  logic                             host_cmd_valid;
  logic [31:0]                      host_cmd_rd_data;

  logic [31:0] rng_state;
  int          errors;
  int          test_errors;
  int          tests_run;

  // Reference model
  logic [CORE_COUNT-1:0]   enable_model;
  logic [CORE_COUNT-1:0]   income_model;
  int                      model_count [CORE_COUNT];
  logic                    in_use [CORE_COUNT][2**SLOT_WIDTH];
  logic [ID_TAG_WIDTH-1:0] free_q [$];
  logic [WORD_BITS-1:0]    exp_q [IF_COUNT][$];
  logic [IF_COUNT-1:0]     in_pkt;
  logic [ID_TAG_WIDTH-1:0] pkt_tag [IF_COUNT];

  rx_scheduler uut (
    .clk              (clk),
    .rst_r            (rst_r),
    .rx_tdata         (rx_tdata),
    .rx_tkeep         (rx_tkeep),
    .rx_tvalid        (rx_tvalid),
    .rx_tready        (rx_tready),
    .rx_tlast         (rx_tlast),
    .data_tdata       (data_tdata),
    .data_tkeep       (data_tkeep),
    .data_tdest       (data_tdest),
    .data_tvalid      (data_tvalid),
    .data_tready      (data_tready),
    .data_tlast       (data_tlast),
    .ctrl_tdata       (ctrl_tdata),
    .ctrl_tvalid      (ctrl_tvalid),
    .ctrl_tuser       (ctrl_tuser),
    .host_cmd         (host_cmd),
    .host_cmd_wr_data (host_cmd_wr_data),
    .host_cmd_valid   (host_cmd_valid),
    .host_cmd_rd_data (host_cmd_rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] rand32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Write, group, scheduler select, index in 6:4, register in 3:0
  function automatic logic [31:0] cmd_word(input logic wr, input logic [4:0] r, input int idx);
    return {wr, r[4], 1'b1, 22'd0, idx[2:0], r[3:0]};
  endfunction

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("mismatch %s: got %h, expected %h", name, got, exp);
    errors++;
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("** FAIL **");
    $finish;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == test_errors) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      $display("test %0d %s: failed with %0d errors", tests_run, name, errors - test_errors);
    end
    test_errors = errors;
  endtask

  task automatic host_write(input logic [4:0] r, input int idx, input logic [31:0] data);
    tick();
    host_cmd         = cmd_word(1'b1, r, idx);
    host_cmd_wr_data = data;
    host_cmd_valid   = 1'b1;
    tick();
    host_cmd_valid = 1'b0;
    tick();
  endtask

  task automatic host_read(input logic [4:0] r, input int idx, output logic [31:0] data);
    tick();
    host_cmd = cmd_word(1'b0, r, idx);
    repeat (4) tick();
    data = host_cmd_rd_data;
  endtask

  task automatic expect_read(input logic [4:0] r, input int idx, input logic [31:0] exp);
    logic [31:0] rd;
    host_read(r, idx, rd);
    if (rd !== exp) begin
      report_mismatch($sformatf("host_cmd_rd_data (reg %h, index %0d)", r, idx),
                      64'(rd), 64'(exp));
    end
  endtask

  task automatic drive_ctrl(input msg_type_e t, input int core, input int slot);
    ctrl_tdata = '0;
    ctrl_tdata[CTRL_WIDTH-1 -: MSG_TYPE_WIDTH]   = t;
    ctrl_tdata[CTRL_SLOT_LSB +: SLOT_WIDTH]      = SLOT_WIDTH'(slot);
    ctrl_tuser  = CORE_ID_WIDTH'(core);
    ctrl_tvalid = 1'b1;
  endtask

  task automatic ctrl_send(input msg_type_e t, input int core, input int slot);
    tick();
    drive_ctrl(t, core, slot);
    tick();
    ctrl_tvalid = 1'b0;
  endtask

  // Compares one word handed to a core with what the port accepted
  task automatic check_delivery(input int p);
    logic [WORD_BITS-1:0]    exp;
    logic [ID_TAG_WIDTH-1:0] dest;
    logic [CORE_ID_WIDTH-1:0] core;
    logic [SLOT_WIDTH-1:0]   slot;
    dest = data_tdest[p*ID_TAG_WIDTH +: ID_TAG_WIDTH];
    core = dest[ID_TAG_WIDTH-1 -: CORE_ID_WIDTH];
    slot = dest[SLOT_WIDTH-1:0];
    if (exp_q[p].size() == 0) begin
      $display("port %0d delivered a word that was never sent", p);
      errors++;
    end else begin
      exp = exp_q[p].pop_front();
      if (data_tdata[p*DATA_WIDTH +: DATA_WIDTH] !== exp[DATA_WIDTH-1:0]) begin
        report_mismatch($sformatf("data_tdata[%0d]", p),
                        64'(data_tdata[p*DATA_WIDTH +: DATA_WIDTH]), 64'(exp[DATA_WIDTH-1:0]));
      end
      if (data_tkeep[p*KEEP_WIDTH +: KEEP_WIDTH] !== exp[DATA_WIDTH +: KEEP_WIDTH]) begin
        report_mismatch($sformatf("data_tkeep[%0d]", p),
                        64'(data_tkeep[p*KEEP_WIDTH +: KEEP_WIDTH]),
                        64'(exp[DATA_WIDTH +: KEEP_WIDTH]));
      end
      if (data_tlast[p] !== exp[WORD_BITS-1]) begin
        report_mismatch($sformatf("data_tlast[%0d]", p), 64'(data_tlast[p]),
                        64'(exp[WORD_BITS-1]));
      end
    end
    if (!in_pkt[p]) begin
      in_pkt[p]  = 1'b1;
      pkt_tag[p] = dest;
      if (!income_model[core]) begin
        $display("port %0d sent a packet to core %0d, which is closed for income", p, core);
        errors++;
      end
      if (in_use[core][slot]) begin
        $display("slot %0d of core %0d was handed out twice without a release", slot, core);
        errors++;
      end
      in_use[core][slot] = 1'b1;
    end else if (dest !== pkt_tag[p]) begin
      report_mismatch($sformatf("data_tdest[%0d]", p), 64'(dest), 64'(pkt_tag[p]));
    end
    if (data_tlast[p]) begin
      in_pkt[p] = 1'b0;
      free_q.push_back(pkt_tag[p]);
    end
  endtask

  initial begin
    logic [31:0]             rd;
    logic [31:0]             rd2;
    logic [31:0]             r;
    logic [31:0]             seen;
    logic [ID_TAG_WIDTH-1:0] tag;
    logic [DATA_WIDTH-1:0]   held_word;
    logic [IF_COUNT-1:0]     accepted;
    logic                    done;
    logic                    leaked;
    int                      pkts_left [IF_COUNT];
    int                      words_left [IF_COUNT];
    int                      wait_cnt;
    int                      cycles;

    rng_state        = 32'hfff8;
    errors           = 0;
    test_errors      = 0;
    tests_run        = 0;
    rst_r            = 1'b1;
    rx_tdata         = '0;
    rx_tkeep         = '0;
    rx_tvalid        = '0;
    rx_tlast         = '0;
    data_tready      = '0;
    ctrl_tdata       = '0;
    ctrl_tvalid      = 1'b0;
    ctrl_tuser       = '0;
    host_cmd         = '0;
    host_cmd_wr_data = '0;
    host_cmd_valid   = 1'b0;
    enable_model     = '0;
    income_model     = '0;
    in_pkt           = '0;
    for (int c = 0; c < CORE_COUNT; c++) begin
      model_count[c] = 0;
      for (int s = 0; s < 2**SLOT_WIDTH; s++) begin
        in_use[c][s] = 1'b0;
      end
    end
    repeat (8) @(posedge clk);
    #1;
    rst_r = 1'b0;

    // Ports must stay closed while no core has a slot
    rx_tvalid   = '1;
    data_tready = '1;
    for (int i = 0; i < 20; i++) begin
      tick();
      #2;
      if (rx_tready !== '0) report_mismatch("rx_tready", 64'(rx_tready), 64'd0);
      if (data_tvalid !== '0) report_mismatch("data_tvalid", 64'(data_tvalid), 64'd0);
    end
    rx_tvalid   = '0;
    data_tready = '0;
    expect_read(REG_CORE_ENABLE, 0, 32'd0);
    expect_read(REG_CORE_INCOME, 0, 32'd0);
    for (int c = 0; c < CORE_COUNT; c++) begin
      expect_read(REG_SLOT_COUNT, c, 32'd0);
    end
    for (int p = 0; p < IF_COUNT; p++) begin
      expect_read(REG_PORT_STATUS, p, 32'd0);
    end
    expect_read(5'h07, 0, HOST_RD_DEFAULT);
    finish_test("reset state");

    host_write(REG_CORE_ENABLE, 0, 32'h0000_00f0);
    enable_model = 8'hf0;
    host_write(REG_CORE_INCOME, 0, 32'h0000_003c);
    income_model = 8'h3c & enable_model;
    expect_read(REG_CORE_ENABLE, 0, 32'(enable_model));
    expect_read(REG_CORE_INCOME, 0, 32'(income_model));
    host_write(REG_CORE_ENABLE, 0, 32'h0000_0024);
    enable_model = 8'h24;
    income_model = income_model & enable_model;
    expect_read(REG_CORE_ENABLE, 0, 32'(enable_model));
    expect_read(REG_CORE_INCOME, 0, 32'(income_model));
    host_write(REG_CORE_INCOME, 0, 32'h0);
    income_model = '0;
    expect_read(REG_CORE_INCOME, 0, 32'(income_model));
    finish_test("core masks");

    ctrl_send(SLOT_INIT, 2, 10);
    ctrl_send(SLOT_INIT, 5, 3);
    model_count[2] = 10;
    model_count[5] = 3;
    expect_read(REG_SLOT_COUNT, 2, 32'(model_count[2]));
    expect_read(REG_SLOT_COUNT, 5, 32'(model_count[5]));
    host_write(REG_CORE_INCOME, 0, 32'h0000_0024);
    income_model = 8'h24 & enable_model;
    // Every idle port prefetches from the fuller core 2
    model_count[2] = model_count[2] - IF_COUNT;
    wait_cnt = 0;
    host_read(REG_SLOT_COUNT, 2, rd);
    while (rd !== 32'(model_count[2]) && wait_cnt < 20) begin
      wait_cnt++;
      host_read(REG_SLOT_COUNT, 2, rd);
    end
    if (rd !== 32'(model_count[2])) abort_on_timeout("the ports to prefetch descriptors");
    expect_read(REG_SLOT_COUNT, 5, 32'(model_count[5]));
    seen = '0;
    for (int p = 0; p < IF_COUNT; p++) begin
      host_read(REG_PORT_STATUS, p, rd);
      if (rd[17:16] !== FIRST) begin
        report_mismatch($sformatf("host_cmd_rd_data[17:16] (port %0d state)", p),
                        64'(rd[17:16]), 64'(FIRST));
      end
      if (rd[10:8] !== 3'd2) begin
        report_mismatch($sformatf("host_cmd_rd_data[10:8] (port %0d core)", p),
                        64'(rd[10:8]), 64'd2);
      end
      if (rd[4:0] == 5'd0 || rd[4:0] > 5'd3 || seen[rd[4:0]]) begin
        $display("port %0d holds slot %0d, not a fresh one of slots 1 to 3", p, rd[4:0]);
        errors++;
      end else begin
        seen[rd[4:0]] = 1'b1;
      end
    end
    finish_test("descriptor prefetch");

    for (int p = 0; p < IF_COUNT; p++) begin
      pkts_left[p]  = PKTS_PER_PORT;
      words_left[p] = 0;
    end
    accepted = '0;
    cycles   = 0;
    done     = 1'b0;
    while (!done && cycles < 4000) begin
      tick();
      cycles++;
      ctrl_tvalid = 1'b0;
      if (free_q.size() > 0) begin
        tag = free_q.pop_front();
        in_use[tag[ID_TAG_WIDTH-1 -: CORE_ID_WIDTH]][tag[SLOT_WIDTH-1:0]] = 1'b0;
        drive_ctrl(SLOT_FREE, int'(tag[ID_TAG_WIDTH-1 -: CORE_ID_WIDTH]),
                   int'(tag[SLOT_WIDTH-1:0]));
      end
      for (int p = 0; p < IF_COUNT; p++) begin
        if (accepted[p]) begin
          rx_tvalid[p] = 1'b0;
          words_left[p]--;
        end
        if (!rx_tvalid[p] && words_left[p] == 0 && pkts_left[p] > 0) begin
          words_left[p] = 1 + int'(rand32() % MAX_PKT_WORDS);
          pkts_left[p]--;
        end
        r = rand32();
        if (!rx_tvalid[p] && words_left[p] > 0 && r[1:0] != 2'b00) begin
          rx_tvalid[p] = 1'b1;
          rx_tdata[p*DATA_WIDTH +: DATA_WIDTH] = {rand32(), rand32()};
          rx_tkeep[p*KEEP_WIDTH +: KEEP_WIDTH] = r[15:8];
          rx_tlast[p] = (words_left[p] == 1);
        end
        r = rand32();
        data_tready[p] = (r[1:0] != 2'b00);
      end
      accepted = '0;
      #2;
      for (int p = 0; p < IF_COUNT; p++) begin
        if (rx_tvalid[p] && rx_tready[p]) begin
          accepted[p] = 1'b1;
          exp_q[p].push_back({rx_tlast[p], rx_tkeep[p*KEEP_WIDTH +: KEEP_WIDTH],
                              rx_tdata[p*DATA_WIDTH +: DATA_WIDTH]});
        end
        if (data_tvalid[p] && data_tready[p]) check_delivery(p);
      end
      done = (free_q.size() == 0);
      for (int p = 0; p < IF_COUNT; p++) begin
        if (pkts_left[p] != 0 || words_left[p] != 0 || exp_q[p].size() != 0) done = 1'b0;
      end
    end
    if (!done) abort_on_timeout("the random packets to drain");
    tick();
    ctrl_tvalid = 1'b0;
    data_tready = '0;
    repeat (20) tick();
    // Each port again holds one prefetched descriptor and no slot is lost
    host_read(REG_SLOT_COUNT, 2, rd);
    host_read(REG_SLOT_COUNT, 5, rd2);
    if (rd + rd2 !== 32'(model_count[2] + model_count[5])) begin
      report_mismatch("host_cmd_rd_data (free slot total)", 64'(rd + rd2),
                      64'(model_count[2] + model_count[5]));
    end
    finish_test("random packets");

    host_write(REG_CORE_INCOME, 0, 32'h0000_0020);
    income_model = 8'h20 & enable_model;
    expect_read(REG_CORE_INCOME, 0, 32'(income_model));
    host_write(REG_SLOT_FLUSH, 0, 32'h0000_0020);
    model_count[5] = 0;
    expect_read(REG_SLOT_COUNT, 5, 32'(model_count[5]));
    // One short packet uses up the descriptor port 0 still holds
    tick();
    rx_tdata[DATA_WIDTH-1:0] = {rand32(), rand32()};
    rx_tkeep[KEEP_WIDTH-1:0] = 8'hff;
    rx_tlast[0]    = 1'b1;
    rx_tvalid[0]   = 1'b1;
    data_tready[0] = 1'b1;
    wait_cnt = 0;
    #2;
    while (!rx_tready[0] && wait_cnt < 50) begin
      tick();
      #2;
      wait_cnt++;
    end
    if (!rx_tready[0]) abort_on_timeout("port 0 to take its last prefetched packet");
    tick();
    held_word = {rand32(), rand32()};
    rx_tdata[DATA_WIDTH-1:0] = held_word;
    leaked = 1'b0;
    for (int i = 0; i < 200; i++) begin
      #2;
      if (data_tvalid[0]) leaked = 1'b1;
      tick();
    end
    if (leaked) begin
      $display("port 0 delivered a packet while core 5 had no free slot");
      errors++;
    end
    drive_ctrl(SLOT_FREE, 5, 4);
    tick();
    ctrl_tvalid = 1'b0;
    wait_cnt = 0;
    #2;
    while (!data_tvalid[0] && wait_cnt < 50) begin
      tick();
      #2;
      wait_cnt++;
    end
    if (!data_tvalid[0]) abort_on_timeout("the held packet after a slot release");
    if (data_tdest[ID_TAG_WIDTH-1:0] !== {3'd5, 5'd4}) begin
      report_mismatch("data_tdest[0]", 64'(data_tdest[ID_TAG_WIDTH-1:0]), 64'({3'd5, 5'd4}));
    end
    if (data_tdata[DATA_WIDTH-1:0] !== held_word) begin
      report_mismatch("data_tdata[0]", 64'(data_tdata[DATA_WIDTH-1:0]), 64'(held_word));
    end
    tick();
    rx_tvalid = '0;
    finish_test("flush and release");

    $display("%0d tests run, %0d errors", tests_run, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire
